//--- hw/fei4_rx_pkg.sv
// Shared types, 8b10b control codes and register offsets of the FE-I4 receiver.
package fei4_rx_pkg;

    // One decoded symbol from the 8b10b decoder.
    typedef struct packed {
        logic       k;
        logic [7:0] data;
        logic       err;
    } rx_sym_t;

    typedef struct packed {
        logic enable;
        logic soft_rst;
        logic clr_err;
    } rx_ctrl_t;

    typedef struct packed {
        logic       ready;
        logic       dec_err;
        logic       ovf_err;
        logic [7:0] lost_cnt;
    } rx_stat_t;

    localparam logic [7:0] K28_5 = 8'hBC;
    localparam logic [7:0] K28_7 = 8'hFC;
    localparam logic [7:0] K28_1 = 8'h3C;

    // Symbols are held as {a,b,c,d,e,i,f,g,h,j}, bit a arrives first and sits in bit 9.
    localparam logic [9:0] COMMA_N = 10'b0011111010;
    localparam logic [9:0] COMMA_P = 10'b1100000101;

    localparam logic [1:0] REG_RESET  = 2'd0;
    localparam logic [1:0] REG_CTRL   = 2'd1;
    localparam logic [1:0] REG_STATUS = 2'd2;
    localparam logic [1:0] REG_LOST   = 2'd3;

endpackage

//--- hw/fei4_rx_regs.sv
// Register file of the receiver; decodes four bytes at BASEADDR on the 8-bit bus.
`timescale 1ns/1ps

module fei4_rx_regs #(
    parameter int                   ABUSWIDTH = 16,
    parameter logic [ABUSWIDTH-1:0] BASEADDR  = '0
) (
    input  logic                  bus_clk,
    input  logic                  arst_n,
    input  logic [ABUSWIDTH-1:0]  bus_add,
    input  logic [7:0]            bus_data_in,
    input  logic                  bus_rd,
    input  logic                  bus_wr,
    input  fei4_rx_pkg::rx_stat_t stat,
    output logic [7:0]            bus_data_out,
    output fei4_rx_pkg::rx_ctrl_t ctrl
);
    import fei4_rx_pkg::*;

    logic [ABUSWIDTH-1:0] offset;
    logic                 in_win;
    logic                 wr_reset;
    logic                 wr_ctrl;
    logic                 enable;
    logic                 soft_rst;
    logic                 clr_err;
    logic [7:0]           rd_mux;

    assign offset   = bus_add - BASEADDR;
    // Addresses below BASEADDR wrap to a large offset and fall outside.
    assign in_win   = (offset[ABUSWIDTH-1:2] == '0);
    assign wr_reset = bus_wr && in_win && (offset[1:0] == REG_RESET);
    assign wr_ctrl  = bus_wr && in_win && (offset[1:0] == REG_CTRL);

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            enable   <= 1'b0;
            soft_rst <= 1'b0;
            clr_err  <= 1'b0;
        end else begin
            soft_rst <= wr_reset;
            clr_err  <= wr_ctrl && bus_data_in[1];
            if (wr_reset) begin
                enable <= 1'b0;
            end else if (wr_ctrl) begin
                enable <= bus_data_in[0];
            end
        end
    end

    always_comb begin
        case (offset[1:0])
            REG_CTRL:   rd_mux = {7'd0, enable};
            REG_STATUS: rd_mux = {5'd0, stat.ovf_err, stat.dec_err, stat.ready};
            REG_LOST:   rd_mux = stat.lost_cnt;
            default:    rd_mux = 8'd0;
        endcase
    end

    // Read data is valid for one cycle after the strobe.
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_data_out <= 8'd0;
        end else begin
            bus_data_out <= (bus_rd && in_win) ? rd_mux : 8'd0;
        end
    end

    assign ctrl = '{enable: enable, soft_rst: soft_rst, clr_err: clr_err};

endmodule

//--- hw/fei4_rx_align.sv
// Symbol aligner; locks the 10-bit boundary on K28.5 commas and strobes each symbol.
`timescale 1ns/1ps

module fei4_rx_align (
    input  logic       bus_clk,
    input  logic       arst_n,
    input  logic       rx_data,
    input  logic       enable,
    input  logic       soft_rst,
    output logic [9:0] sym,
    output logic       sym_stb,
    output logic       ready
);
    import fei4_rx_pkg::*;

    logic [9:0] shreg;
    logic [3:0] bit_cnt;
    logic       seen;
    logic       comma;
    logic       wrap;

    assign comma = (shreg == COMMA_P) || (shreg == COMMA_N);
    // A full symbol sits in the shift register when the counter wraps.
    assign wrap  = (bit_cnt == 4'd9);

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            shreg   <= '0;
            bit_cnt <= '0;
            seen    <= 1'b0;
            ready   <= 1'b0;
            sym_stb <= 1'b0;
        end else if (soft_rst || !enable) begin
            shreg   <= '0;
            bit_cnt <= '0;
            seen    <= 1'b0;
            ready   <= 1'b0;
            sym_stb <= 1'b0;
        end else begin
            shreg   <= {shreg[8:0], rx_data};
            sym_stb <= ready && wrap;
            if (!ready && comma) begin
                // Restart the count at every comma until two agree.
                bit_cnt <= '0;
                seen    <= 1'b1;
                if (seen && wrap) begin
                    ready <= 1'b1;
                end
            end else begin
                bit_cnt <= wrap ? 4'd0 : bit_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (wrap) begin
            sym <= shreg;
        end
    end

    // Strobes come only while locked, and never closer than one symbol apart.
    a_stb_spacing: assert property (@(posedge bus_clk) disable iff (!arst_n)
        sym_stb |-> ready ##1 !sym_stb [*9])
        else $error("symbol strobe without lock or closer than ten clocks");

endmodule

//--- hw/fei4_rx_dec8b10b.sv
// 8b10b decoder with code and running disparity checks, one symbol per strobe.
`timescale 1ns/1ps

module fei4_rx_dec8b10b (
    input  logic                 bus_clk,
    input  logic                 arst_n,
    input  logic [9:0]           sym,
    input  logic                 sym_stb,
    input  logic                 soft_rst,
    output fei4_rx_pkg::rx_sym_t out,
    output logic                 out_stb
);
    import fei4_rx_pkg::*;

    logic [5:0] s6;
    logic [3:0] s4;
    logic [3:0] s4_adj;
    logic [4:0] d5;
    logic [2:0] d3;
    logic       v6;
    logic       v4;
    logic       k28;
    logic       p6, n6, p4, n4;
    logic       rd;
    logic       rd_mid;
    logic       rd_next;
    logic       err6;
    logic       err4;

    assign s6  = sym[9:4];
    assign s4  = sym[3:0];
    assign k28 = (s6 == 6'b001111) || (s6 == 6'b110000);
    // The K28 positive form swaps the 4b column, so invert before the table.
    assign s4_adj = (s6 == 6'b110000) ? ~s4 : s4;

    always_comb begin
        v6 = 1'b1;
        case (s6)
            6'b100111, 6'b011000: d5 = 5'd0;
            6'b011101, 6'b100010: d5 = 5'd1;
            6'b101101, 6'b010010: d5 = 5'd2;
            6'b110001:            d5 = 5'd3;
            6'b110101, 6'b001010: d5 = 5'd4;
            6'b101001:            d5 = 5'd5;
            6'b011001:            d5 = 5'd6;
            6'b111000, 6'b000111: d5 = 5'd7;
            6'b111001, 6'b000110: d5 = 5'd8;
            6'b100101:            d5 = 5'd9;
            6'b010101:            d5 = 5'd10;
            6'b110100:            d5 = 5'd11;
            6'b001101:            d5 = 5'd12;
            6'b101100:            d5 = 5'd13;
            6'b011100:            d5 = 5'd14;
            6'b010111, 6'b101000: d5 = 5'd15;
            6'b011011, 6'b100100: d5 = 5'd16;
            6'b100011:            d5 = 5'd17;
            6'b010011:            d5 = 5'd18;
            6'b110010:            d5 = 5'd19;
            6'b001011:            d5 = 5'd20;
            6'b101010:            d5 = 5'd21;
            6'b011010:            d5 = 5'd22;
            6'b111010, 6'b000101: d5 = 5'd23;
            6'b110011, 6'b001100: d5 = 5'd24;
            6'b100110:            d5 = 5'd25;
            6'b010110:            d5 = 5'd26;
            6'b110110, 6'b001001: d5 = 5'd27;
            6'b001110, 6'b001111,
            6'b110000:            d5 = 5'd28;
            6'b101110, 6'b010001: d5 = 5'd29;
            6'b011110, 6'b100001: d5 = 5'd30;
            6'b101011, 6'b010100: d5 = 5'd31;
            default: begin
                d5 = 5'd0;
                v6 = 1'b0;
            end
        endcase
    end

    always_comb begin
        v4 = 1'b1;
        case (s4_adj)
            4'b1011, 4'b0100: d3 = 3'd0;
            4'b1001:          d3 = 3'd1;
            4'b0101:          d3 = 3'd2;
            4'b1100, 4'b0011: d3 = 3'd3;
            4'b1101, 4'b0010: d3 = 3'd4;
            4'b1010:          d3 = 3'd5;
            4'b0110:          d3 = 3'd6;
            4'b1110, 4'b0001,
            4'b0111, 4'b1000: d3 = 3'd7;
            default: begin
                d3 = 3'd0;
                v4 = 1'b0;
            end
        endcase
    end

    // Disparity of each sub-block; rd high means positive.
    assign p6 = ($countones(s6) == 4);
    assign n6 = ($countones(s6) == 2);
    assign p4 = ($countones(s4) == 3);
    assign n4 = ($countones(s4) == 1);

    assign err6 = (p6 && rd) || (n6 && !rd) ||
                  (s6 == 6'b111000 && rd) || (s6 == 6'b000111 && !rd);
    assign rd_mid  = rd ^ (p6 || n6);
    assign err4 = (p4 && rd_mid) || (n4 && !rd_mid) ||
                  (s4 == 4'b1100 && rd_mid) || (s4 == 4'b0011 && !rd_mid);
    assign rd_next = rd_mid ^ (p4 || n4);

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd      <= 1'b0;
            out_stb <= 1'b0;
        end else if (soft_rst) begin
            rd      <= 1'b0;
            out_stb <= 1'b0;
        end else begin
            out_stb <= sym_stb;
            if (sym_stb) begin
                rd <= rd_next;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (sym_stb) begin
            out <= '{k: k28, data: {d3, d5}, err: !v6 || !v4 || err6 || err4};
        end
    end

endmodule

//--- hw/fei4_rx_framer.sv
// Record framer; packs three data bytes of a frame into one tagged 32-bit word.
`timescale 1ns/1ps

module fei4_rx_framer #(
    parameter logic [7:0] DATA_IDENTIFIER = 8'h00
) (
    input  logic                 bus_clk,
    input  logic                 arst_n,
    input  fei4_rx_pkg::rx_sym_t in,
    input  logic                 in_stb,
    input  logic                 soft_rst,
    output logic [31:0]          wr_data,
    output logic                 wr_en,
    output logic                 dec_err_pulse
);
    import fei4_rx_pkg::*;

    logic        in_frame;
    logic [1:0]  byte_cnt;
    logic [15:0] head;
    logic        sof;
    logic        eof;
    logic        take;

    // Symbols with a decode error carry no usable byte.
    assign sof  = in_stb && !in.err && in.k && (in.data == K28_7);
    assign eof  = in_stb && !in.err && in.k && (in.data == K28_5);
    assign take = in_stb && !in.err && !in.k && in_frame;

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            in_frame      <= 1'b0;
            byte_cnt      <= '0;
            wr_en         <= 1'b0;
            dec_err_pulse <= 1'b0;
        end else if (soft_rst) begin
            in_frame      <= 1'b0;
            byte_cnt      <= '0;
            wr_en         <= 1'b0;
            dec_err_pulse <= 1'b0;
        end else begin
            wr_en         <= take && (byte_cnt == 2'd2);
            dec_err_pulse <= in_stb && in.err;
            if (sof || eof) begin
                // A partial record is dropped at either frame boundary.
                in_frame <= sof;
                byte_cnt <= '0;
            end else if (take) begin
                byte_cnt <= (byte_cnt == 2'd2) ? 2'd0 : byte_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (take) begin
            if (byte_cnt == 2'd2) begin
                wr_data <= {DATA_IDENTIFIER, head, in.data};
            end else begin
                head <= {head[7:0], in.data};
            end
        end
    end

    a_wr_single: assert property (@(posedge bus_clk) disable iff (!arst_n)
        wr_en |=> !wr_en)
        else $error("FIFO write held longer than one cycle");

endmodule

//--- hw/fei4_rx_fifo.sv
// First-word-fall-through FIFO for records; drops and flags writes while full.
`timescale 1ns/1ps

module fei4_rx_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic        bus_clk,
    input  logic        arst_n,
    input  logic        soft_rst,
    input  logic [31:0] wr_data,
    input  logic        wr_en,
    input  logic        rd_en,
    output logic [31:0] rd_data,
    output logic        empty,
    output logic        full,
    output logic        ovf
);
    localparam int AW = $clog2(FIFO_DEPTH);

    logic [31:0] mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        push;
    logic        pop;

    // Extra pointer bit tells full from empty.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign push  = wr_en && !full;
    assign pop   = rd_en && !empty;

    assign rd_data = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            ovf    <= 1'b0;
        end else if (soft_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            ovf    <= 1'b0;
        end else begin
            ovf <= wr_en && full;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

    a_no_pop_empty: assert property (@(posedge bus_clk) disable iff (!arst_n)
        rd_en |-> !empty)
        else $error("read from empty FIFO");

endmodule

//--- hw/fei4_rx.sv
// Top level of the FE-I4 serial receiver; aligner, decoder, framer, FIFO and registers.
`timescale 1ns/1ps

module fei4_rx #(
    parameter int                   ABUSWIDTH       = 16,
    parameter logic [ABUSWIDTH-1:0] BASEADDR        = '0,
    parameter logic [7:0]           DATA_IDENTIFIER = 8'h00,
    parameter int                   FIFO_DEPTH      = 16
) (
    input  logic                 bus_clk,
    input  logic                 arst_n,
    input  logic [ABUSWIDTH-1:0] bus_add,
    input  logic [7:0]           bus_data_in,
    input  logic                 bus_rd,
    input  logic                 bus_wr,
    output logic [7:0]           bus_data_out,
    input  logic                 rx_data,
    output logic                 rx_ready,
    output logic                 rx_8b10b_decoder_err,
    output logic                 rx_fifo_overflow_err,
    input  logic                 fifo_read,
    output logic                 fifo_empty,
    output logic [31:0]          fifo_data,
    output logic                 rx_fifo_full
);
    import fei4_rx_pkg::*;

    rx_ctrl_t    ctrl;
    rx_stat_t    stat;
    rx_sym_t     dec_sym;
    logic [9:0]  sym;
    logic        sym_stb;
    logic        dec_stb;
    logic        ready;
    logic [31:0] wr_data;
    logic        wr_en;
    logic        dec_err_pulse;
    logic        ovf;
    logic        dec_err;
    logic        ovf_err;
    logic [7:0]  lost_cnt;
    logic        clr;

    assign clr = ctrl.clr_err || ctrl.soft_rst;

    fei4_rx_regs #(.ABUSWIDTH(ABUSWIDTH), .BASEADDR(BASEADDR)) fei4_rx_regs_i (
        .bus_clk, .arst_n, .bus_add, .bus_data_in, .bus_rd, .bus_wr,
        .stat, .bus_data_out, .ctrl
    );

    fei4_rx_align fei4_rx_align_i (
        .bus_clk, .arst_n, .rx_data, .enable(ctrl.enable), .soft_rst(ctrl.soft_rst),
        .sym, .sym_stb, .ready
    );

    fei4_rx_dec8b10b fei4_rx_dec8b10b_i (
        .bus_clk, .arst_n, .sym, .sym_stb, .soft_rst(ctrl.soft_rst),
        .out(dec_sym), .out_stb(dec_stb)
    );

    fei4_rx_framer #(.DATA_IDENTIFIER(DATA_IDENTIFIER)) fei4_rx_framer_i (
        .bus_clk, .arst_n, .in(dec_sym), .in_stb(dec_stb), .soft_rst(ctrl.soft_rst),
        .wr_data, .wr_en, .dec_err_pulse
    );

    fei4_rx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fei4_rx_fifo_i (
        .bus_clk, .arst_n, .soft_rst(ctrl.soft_rst), .wr_data, .wr_en,
        .rd_en(fifo_read), .rd_data(fifo_data), .empty(fifo_empty),
        .full(rx_fifo_full), .ovf
    );

    // Sticky error flags.
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_err <= 1'b0;
            ovf_err <= 1'b0;
        end else if (clr) begin
            dec_err <= 1'b0;
            ovf_err <= 1'b0;
        end else begin
            dec_err <= dec_err || dec_err_pulse;
            ovf_err <= ovf_err || ovf;
        end
    end

    // Dropped words, saturating at 255.
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            lost_cnt <= 8'd0;
        end else if (clr) begin
            lost_cnt <= 8'd0;
        end else if (ovf && lost_cnt != 8'hFF) begin
            lost_cnt <= lost_cnt + 8'd1;
        end
    end

    assign stat = '{ready: ready, dec_err: dec_err, ovf_err: ovf_err, lost_cnt: lost_cnt};

    assign rx_ready             = ready;
    assign rx_8b10b_decoder_err = dec_err;
    assign rx_fifo_overflow_err = ovf_err;

endmodule

//--- verif/fei4_rx_clk_gen.sv
// Free-running testbench clock source; instantiate once and connect clk to the DUT clock.
`timescale 1ns/1ps

module fei4_rx_clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

//--- verif/fei4_rx_tb.sv
// Testbench for the FE-I4 receiver; serializes 8b10b symbols and checks records and registers.
`timescale 1ns/1ps

module fei4_rx_tb;
    import fei4_rx_pkg::*;

    localparam int                   ABUSWIDTH       = 16;
    localparam logic [ABUSWIDTH-1:0] BASEADDR        = 16'h1000;
    localparam logic [7:0]           DATA_IDENTIFIER = 8'hA5;
    localparam int                   FIFO_DEPTH      = 16;

    // RD- forms of the 5b/6b and 3b/4b codes, abcdei and fghj with a first.
    localparam logic [5:0] SIX_B [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
    };
    localparam logic [3:0] FOUR_B [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
    };
    localparam logic [3:0] K_FOUR_B [8] = '{
        4'b0100, 4'b1001, 4'b0101, 4'b0011, 4'b0010, 4'b1010, 4'b0110, 4'b1000
    };

    // One entry of the serial line; raw entries carry a ready-made 10-bit code.
    typedef struct packed {
        logic       raw;
        logic       k;
        logic [9:0] val;
    } line_sym_t;

    logic                 bus_clk;
    logic                 arst_n;
    logic [ABUSWIDTH-1:0] bus_add;
    logic [7:0]           bus_data_in;
    logic                 bus_rd;
    logic                 bus_wr;
    logic [7:0]           bus_data_out;
    logic                 rx_data;
    logic                 rx_ready;
    logic                 rx_8b10b_decoder_err;
    logic                 rx_fifo_overflow_err;
    logic                 fifo_read;
    logic                 fifo_empty;
    logic [31:0]          fifo_data;
    logic                 rx_fifo_full;

    line_sym_t   line_q[$];
    logic [31:0] exp_q[$];
    logic        line_on;
    logic        line_busy;
    logic        enc_rd;
    line_sym_t   cur;
    logic [10:0] enc;
    logic [9:0]  code;
    int          bit_i;
    logic [31:0] rng;
    int          errors;
    int          checks;
    int          tests;
    int          err_mark;

    fei4_rx_clk_gen #(.PERIOD_NS(40)) fei4_rx_clk_gen_i (.clk(bus_clk));

    fei4_rx #(
        .ABUSWIDTH(ABUSWIDTH), .BASEADDR(BASEADDR),
        .DATA_IDENTIFIER(DATA_IDENTIFIER), .FIFO_DEPTH(FIFO_DEPTH)
    ) fei4_rx_i (
        .bus_clk, .arst_n, .bus_add, .bus_data_in, .bus_rd, .bus_wr, .bus_data_out,
        .rx_data, .rx_ready, .rx_8b10b_decoder_err, .rx_fifo_overflow_err,
        .fifo_read, .fifo_empty, .fifo_data, .rx_fifo_full
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng = xorshift32(rng);
        return rng % n;
    endfunction

    // Returns {running disparity after the symbol, 10-bit code}.
    function automatic logic [10:0] encode_8b10b(input logic k, input logic [7:0] b,
                                                 input logic rd);
        logic [5:0] c6;
        logic [3:0] c4;
        logic       rd_mid;
        logic       alt;
        c6 = k ? 6'b001111 : SIX_B[b[4:0]];
        if (rd && (($countones(c6) != 3) || (c6 == 6'b111000))) begin
            c6 = ~c6;
        end
        rd_mid = rd ^ ($countones(c6) != 3);
        if (k) begin
            c4 = rd ? ~K_FOUR_B[b[7:5]] : K_FOUR_B[b[7:5]];
        end else begin
            // D.x.A7 avoids a run of five equal bits.
            alt = (b[7:5] == 3'd7) &&
                  ((!rd_mid && (b[4:0] == 5'd17 || b[4:0] == 5'd18 || b[4:0] == 5'd20)) ||
                   (rd_mid && (b[4:0] == 5'd11 || b[4:0] == 5'd13 || b[4:0] == 5'd14)));
            c4 = alt ? 4'b0111 : FOUR_B[b[7:5]];
            if (rd_mid && (($countones(c4) != 2) || (c4 == 4'b1100))) begin
                c4 = ~c4;
            end
        end
        return {rd_mid ^ ($countones(c4) != 2), c6, c4};
    endfunction

    // Serial line; sends queued symbols first bit first, idle K28.1 when nothing waits.
    always begin
        @(negedge bus_clk);
        if (!line_on) begin
            rx_data = 1'b0;
        end else begin
            if (line_q.size() > 0) begin
                cur       = line_q.pop_front();
                line_busy = 1'b1;
            end else begin
                cur = '{raw: 1'b0, k: 1'b1, val: {2'b00, K28_1}};
            end
            if (cur.raw) begin
                code = cur.val;
            end else begin
                enc    = encode_8b10b(cur.k, cur.val[7:0], enc_rd);
                code   = enc[9:0];
                enc_rd = enc[10];
            end
            for (bit_i = 9; bit_i >= 0; bit_i--) begin
                if (bit_i != 9) begin
                    @(negedge bus_clk);
                end
                rx_data = code[bit_i];
            end
            line_busy = 1'b0;
        end
    end

    task check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        end
    endtask

    task bus_write(input logic [1:0] off, input logic [7:0] data);
        @(negedge bus_clk);
        bus_add     = BASEADDR + off;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(negedge bus_clk);
        bus_wr  = 1'b0;
        bus_add = '0;
    endtask

    task bus_read(input logic [1:0] off, output logic [7:0] data);
        @(negedge bus_clk);
        bus_add = BASEADDR + off;
        bus_rd  = 1'b1;
        @(negedge bus_clk);
        data    = bus_data_out;
        bus_rd  = 1'b0;
        bus_add = '0;
    endtask

    task check_reg(input logic [1:0] off, input string name, input logic [7:0] exp);
        logic [7:0] v;
        bus_read(off, v);
        check_equal(name, exp, v);
    endtask

    // Queues one frame of n random bytes and the records the framer must build from it.
    task push_frame(input int n);
        logic [7:0] b [3];
        line_q.push_back('{raw: 1'b0, k: 1'b1, val: {2'b00, K28_7}});
        for (int i = 0; i < n; i++) begin
            b[i % 3] = rand_below(256);
            line_q.push_back('{raw: 1'b0, k: 1'b0, val: {2'b00, b[i % 3]}});
            if (i % 3 == 2) begin
                exp_q.push_back({DATA_IDENTIFIER, b[0], b[1], b[2]});
            end
        end
        line_q.push_back('{raw: 1'b0, k: 1'b1, val: {2'b00, K28_5}});
    endtask

    task wait_not_empty(output bit ok);
        int n;
        n = 0;
        while (fifo_empty && n < 2000) begin
            @(negedge bus_clk);
            n++;
        end
        ok = !fifo_empty;
        if (!ok) begin
            errors++;
            $display("Timeout at %0t ns: no record arrived in the FIFO", $time);
        end
    endtask

    task pop_expect(input logic [31:0] exp);
        bit ok;
        wait_not_empty(ok);
        if (ok) begin
            check_equal("fifo_data", exp, fifo_data);
            fifo_read = 1'b1;
            @(negedge bus_clk);
            fifo_read = 1'b0;
        end
    endtask

    // Waits until the line has sent every queued symbol, then lets the pipeline settle.
    task wait_drained();
        int n;
        n = 0;
        while ((line_q.size() != 0 || line_busy) && n < 5000) begin
            @(negedge bus_clk);
            n++;
        end
        if (line_q.size() != 0 || line_busy) begin
            errors++;
            $display("Timeout at %0t ns: serial line never finished its symbols", $time);
        end
        repeat (30) @(negedge bus_clk);
    endtask

    task start_test();
        err_mark = errors;
        tests++;
    endtask

    task end_test(input string name);
        $display("%-16s %s", name, (errors == err_mark) ? "pass" : "fail");
    endtask

    initial begin
        int n;
        rng         = 32'd12;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        arst_n      = 1'b0;
        bus_add     = '0;
        bus_data_in = 8'd0;
        bus_rd      = 1'b0;
        bus_wr      = 1'b0;
        rx_data     = 1'b0;
        fifo_read   = 1'b0;
        line_on     = 1'b0;
        line_busy   = 1'b0;
        enc_rd      = 1'b0;
        repeat (4) @(posedge bus_clk);
        @(negedge bus_clk);
        arst_n = 1'b1;

        start_test();
        check_reg(REG_STATUS, "bus_data_out (REG_STATUS)", 8'h00);
        check_reg(REG_LOST, "bus_data_out (REG_LOST)", 8'h00);
        check_equal("fifo_empty", 1'b1, fifo_empty);
        check_equal("rx_ready", 1'b0, rx_ready);
        end_test("reset values");

        start_test();
        bus_write(REG_CTRL, 8'h01);
        repeat (rand_below(10)) @(negedge bus_clk);
        line_q.push_back('{raw: 1'b0, k: 1'b1, val: {2'b00, K28_5}});
        line_q.push_back('{raw: 1'b0, k: 1'b1, val: {2'b00, K28_5}});
        line_on = 1'b1;
        n = 0;
        while (!rx_ready && n < 60) begin
            @(negedge bus_clk);
            n++;
        end
        if (!rx_ready) begin
            errors++;
            $display("Timeout at %0t ns: rx_ready did not rise within 60 clocks", $time);
        end
        check_reg(REG_STATUS, "bus_data_out (REG_STATUS)", 8'h01);
        end_test("alignment");

        start_test();
        for (int f = 0; f < 8; f++) begin
            n = 3 * (1 + rand_below(4));
            if (rand_below(4) == 0) begin
                n = n + 1 + rand_below(2);
            end
            push_frame(n);
        end
        while (exp_q.size() > 0) begin
            pop_expect(exp_q.pop_front());
        end
        wait_drained();
        check_equal("fifo_empty", 1'b1, fifo_empty);
        end_test("record path");

        start_test();
        check_equal("rx_8b10b_decoder_err", 1'b0, rx_8b10b_decoder_err);
        // Balanced code with no 6b entry, so disparity stays the same.
        line_q.push_back('{raw: 1'b1, k: 1'b0, val: 10'b1111100000});
        n = 0;
        while (!rx_8b10b_decoder_err && n < 200) begin
            @(negedge bus_clk);
            n++;
        end
        if (!rx_8b10b_decoder_err) begin
            errors++;
            $display("Timeout at %0t ns: invalid code did not raise the decoder error", $time);
        end
        check_reg(REG_STATUS, "bus_data_out (REG_STATUS)", 8'h03);
        bus_write(REG_CTRL, 8'h03);
        check_reg(REG_STATUS, "bus_data_out (REG_STATUS)", 8'h01);
        check_equal("rx_8b10b_decoder_err", 1'b0, rx_8b10b_decoder_err);
        end_test("decoder error");

        start_test();
        push_frame(3 * (FIFO_DEPTH + 5));
        wait_drained();
        check_equal("rx_fifo_full", 1'b1, rx_fifo_full);
        check_equal("rx_fifo_overflow_err", 1'b1, rx_fifo_overflow_err);
        check_reg(REG_STATUS, "bus_data_out (REG_STATUS)", 8'h05);
        check_reg(REG_LOST, "bus_data_out (REG_LOST)", 8'd5);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            pop_expect(exp_q.pop_front());
        end
        exp_q.delete();
        check_equal("fifo_empty", 1'b1, fifo_empty);
        end_test("overflow");

        start_test();
        push_frame(3);
        wait_not_empty(n[0]);
        exp_q.delete();
        bus_write(REG_RESET, 8'h00);
        n = 0;
        while (rx_ready && n < 10) begin
            @(negedge bus_clk);
            n++;
        end
        if (rx_ready) begin
            errors++;
            $display("Timeout at %0t ns: rx_ready stayed high after soft reset", $time);
        end
        check_equal("fifo_empty", 1'b1, fifo_empty);
        check_equal("rx_8b10b_decoder_err", 1'b0, rx_8b10b_decoder_err);
        check_equal("rx_fifo_overflow_err", 1'b0, rx_fifo_overflow_err);
        check_reg(REG_STATUS, "bus_data_out (REG_STATUS)", 8'h00);
        check_reg(REG_LOST, "bus_data_out (REG_LOST)", 8'h00);
        check_reg(REG_CTRL, "bus_data_out (REG_CTRL)", 8'h00);
        end_test("soft reset");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/fei4_rx_pkg.sv
hw/fei4_rx_regs.sv
hw/fei4_rx_align.sv
hw/fei4_rx_dec8b10b.sv
hw/fei4_rx_framer.sv
hw/fei4_rx_fifo.sv
hw/fei4_rx.sv
verif/fei4_rx_clk_gen.sv
verif/fei4_rx_tb.sv
